//--- common/retire_monitor_pkg.sv
package retire_monitor_pkg;

    //////////////////////////////////////////////////
    // Retired instruction word
    typedef logic [31:0] instr_t;

    //////////////////////////////////////////////////
    // Major opcode field, instruction bits 6 to 2
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        FENCE     = 5'b00011,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        AMO       = 5'b01011,
        ARITH     = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        SYSTEM    = 5'b11100
    } opcode_t;

    //////////////////////////////////////////////////
    // Instruction mix categories
    typedef enum logic [2:0] {
        MIX_ALU    = 3'd0,
        MIX_BRANCH = 3'd1,
        MIX_MUL    = 3'd2,
        MIX_DIV    = 3'd3,
        MIX_LOAD   = 3'd4,
        MIX_STORE  = 3'd5,
        MIX_MISC   = 3'd6
    } mix_category_t;

    localparam int NUM_MIX_CATEGORIES = 7;

    // One bit per category, indexed by mix_category_t
    typedef logic [NUM_MIX_CATEGORIES-1:0] mix_vector_t;

    //////////////////////////////////////////////////
    // Benchmark window markers
    // Both are addi x0, x0, imm so they retire as ALU NOPs
    localparam instr_t START_MARKER_INSTR = 32'h00C0_0013;
    localparam instr_t END_MARKER_INSTR   = 32'h00D0_0013;

endpackage

//--- rtl/mix/mix_classifier.sv
`timescale 1ns/1ps

module mix_classifier #(
    parameter int RETIRE_PORTS = 2
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        retire_valid [RETIRE_PORTS],
    input  retire_monitor_pkg::instr_t  retire_instr [RETIRE_PORTS],
    output retire_monitor_pkg::mix_vector_t port_mix [RETIRE_PORTS],
    output logic                        port_valid_r [RETIRE_PORTS]
);

    import retire_monitor_pkg::*;

    opcode_t     opcode [RETIRE_PORTS];
    logic        is_muldiv [RETIRE_PORTS];
    mix_vector_t mix_next [RETIRE_PORTS];

    //////////////////////////////////////////////////
    // Opcode decode per port
    always_comb begin
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            opcode[i]    = opcode_t'(retire_instr[i][6:2]);
            // M extension sits under ARITH with funct7 bit 0 set
            is_muldiv[i] = retire_instr[i][25];
            mix_next[i]  = '0;

            case (opcode[i])
                ARITH: begin
                    if (!is_muldiv[i]) begin
                        mix_next[i][MIX_ALU] = 1'b1;
                    end else if (retire_instr[i][14]) begin
                        mix_next[i][MIX_DIV] = 1'b1;
                    end else begin
                        mix_next[i][MIX_MUL] = 1'b1;
                    end
                end
                ARITH_IMM, AUIPC, LUI: mix_next[i][MIX_ALU] = 1'b1;
                BRANCH, JAL, JALR:     mix_next[i][MIX_BRANCH] = 1'b1;
                LOAD:                  mix_next[i][MIX_LOAD] = 1'b1;
                STORE:                 mix_next[i][MIX_STORE] = 1'b1;
                AMO: begin
                    // Read-modify-write counts both ways
                    mix_next[i][MIX_LOAD]  = 1'b1;
                    mix_next[i][MIX_STORE] = 1'b1;
                end
                SYSTEM, FENCE:         mix_next[i][MIX_MISC] = 1'b1;
                default:               mix_next[i] = '0;
            endcase

            if (!retire_valid[i]) begin
                mix_next[i] = '0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Output register
    always_ff @(posedge clk) begin
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            if (reset) begin
                port_mix[i]     <= '0;
                port_valid_r[i] <= 1'b0;
            end else begin
                port_mix[i]     <= mix_next[i];
                port_valid_r[i] <= retire_valid[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    for (genvar g = 0; g < RETIRE_PORTS; g++) begin : gen_port_check
        assert property (@(posedge clk) disable iff (reset)
            !$past(retire_valid[g]) |-> (port_mix[g] == '0)
        );
    end

endmodule

//--- rtl/mix/mix_counter_bank.sv
`timescale 1ns/1ps

module mix_counter_bank #(
    parameter int RETIRE_PORTS = 2,
    parameter int COUNTER_W    = 32
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            count_enable,
    input  logic                            count_clear,
    input  retire_monitor_pkg::mix_vector_t port_mix [RETIRE_PORTS],
    input  logic                            port_valid_r [RETIRE_PORTS],
    output logic [COUNTER_W-1:0]            mix_count [retire_monitor_pkg::NUM_MIX_CATEGORIES],
    output logic [COUNTER_W-1:0]            retire_total
);

    import retire_monitor_pkg::*;

    logic [COUNTER_W-1:0] mix_incr [NUM_MIX_CATEGORIES];
    logic [COUNTER_W-1:0] total_incr;

    //////////////////////////////////////////////////
    // Per-cycle increments summed over ports
    always_comb begin
        total_incr = '0;
        for (int c = 0; c < NUM_MIX_CATEGORIES; c++) begin
            mix_incr[c] = '0;
        end
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            total_incr += COUNTER_W'(port_valid_r[p]);
            for (int c = 0; c < NUM_MIX_CATEGORIES; c++) begin
                mix_incr[c] += COUNTER_W'(port_mix[p][c]);
            end
        end
    end

    //////////////////////////////////////////////////
    // Counters, clear over enable, wrap at COUNTER_W
    always_ff @(posedge clk) begin
        if (reset || count_clear) begin
            retire_total <= '0;
            for (int c = 0; c < NUM_MIX_CATEGORIES; c++) begin
                mix_count[c] <= '0;
            end
        end else if (count_enable) begin
            retire_total <= retire_total + total_incr;
            for (int c = 0; c < NUM_MIX_CATEGORIES; c++) begin
                mix_count[c] <= mix_count[c] + mix_incr[c];
            end
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    // Total only moves forward, by at most one per port
    assert property (@(posedge clk) disable iff (reset)
        !count_clear |=> (COUNTER_W'(retire_total - $past(retire_total))
                          <= COUNTER_W'(RETIRE_PORTS))
    );

endmodule

//--- rtl/collection_control.sv
`timescale 1ns/1ps

module collection_control #(
    parameter int RETIRE_PORTS = 2
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       retire_valid [RETIRE_PORTS],
    input  retire_monitor_pkg::instr_t retire_instr [RETIRE_PORTS],
    output logic                       collecting,
    output logic                       count_enable,
    output logic                       count_clear,
    output logic                       window_done
);

    import retire_monitor_pkg::*;

    logic start_hit;
    logic end_hit;

    //////////////////////////////////////////////////
    // Marker detection on any valid port
    always_comb begin
        start_hit = 1'b0;
        end_hit   = 1'b0;
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            start_hit |= retire_valid[i] & (retire_instr[i] == START_MARKER_INSTR);
            end_hit   |= retire_valid[i] & (retire_instr[i] == END_MARKER_INSTR);
        end
    end

    //////////////////////////////////////////////////
    // Window state
    // End marker wins when both retire together
    always_ff @(posedge clk) begin
        if (reset) begin
            collecting <= 1'b0;
        end else if (end_hit) begin
            collecting <= 1'b0;
        end else if (start_hit) begin
            collecting <= 1'b1;
        end
    end

    // Enable trails the window by one cycle to line up with the
    // registered classifier output; clear pulses right after a start
    always_ff @(posedge clk) begin
        if (reset) begin
            count_enable <= 1'b0;
            count_clear  <= 1'b0;
            window_done  <= 1'b0;
        end else begin
            count_enable <= collecting;
            count_clear  <= start_hit & ~end_hit;
            // Enable is about to fall
            window_done  <= count_enable & ~collecting;
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    // Clear overlaps enable only on a restart of an open window
    assert property (@(posedge clk) disable iff (reset)
        (count_clear && count_enable) |-> ($past(collecting) && collecting)
    );

endmodule

//--- rtl/uart_capture.sv
`timescale 1ns/1ps

module uart_capture #(
    parameter logic [31:0] UART_ADDR = 32'h8800_1000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        write_valid,
    input  logic [31:0] write_addr,
    input  logic [31:0] write_data,
    output logic        write_uart,
    output logic [7:0]  uart_byte
);

    logic uart_hit;

    assign uart_hit = write_valid && (write_addr == UART_ADDR);

    // One-cycle strobe per console write
    always_ff @(posedge clk) begin
        if (reset) begin
            write_uart <= 1'b0;
        end else begin
            write_uart <= uart_hit;
        end
    end

    // Byte holds between writes
    always_ff @(posedge clk) begin
        if (uart_hit) begin
            uart_byte <= write_data[7:0];
        end
    end

endmodule

//--- rtl/retire_monitor_top.sv
`timescale 1ns/1ps

module retire_monitor_top #(
    parameter int          RETIRE_PORTS = 2,
    parameter int          COUNTER_W    = 32,
    parameter logic [31:0] UART_ADDR    = 32'h8800_1000
) (
    input  logic                     clk,
    input  logic                     reset,

    // Retire trace
    input  logic                     retire_valid [RETIRE_PORTS],
    input  retire_monitor_pkg::instr_t retire_instr [RETIRE_PORTS],

    // Simulated store path for console output
    input  logic                     write_valid,
    input  logic [31:0]              write_addr,
    input  logic [31:0]              write_data,

    output logic                     collecting,
    output logic                     window_done,
    output logic [COUNTER_W-1:0]     mix_count [retire_monitor_pkg::NUM_MIX_CATEGORIES],
    output logic [COUNTER_W-1:0]     retire_total,
    output logic                     write_uart,
    output logic [7:0]               uart_byte
);

    import retire_monitor_pkg::*;

    logic        count_enable;
    logic        count_clear;
    mix_vector_t port_mix [RETIRE_PORTS];
    logic        port_valid_r [RETIRE_PORTS];

    //////////////////////////////////////////////////
    // Window control
    collection_control #(
        .RETIRE_PORTS (RETIRE_PORTS)
    ) collection_control_0 (
        .clk          (clk),
        .reset        (reset),
        .retire_valid (retire_valid),
        .retire_instr (retire_instr),
        .collecting   (collecting),
        .count_enable (count_enable),
        .count_clear  (count_clear),
        .window_done  (window_done)
    );

    //////////////////////////////////////////////////
    // Instruction mix datapath
    mix_classifier #(
        .RETIRE_PORTS (RETIRE_PORTS)
    ) mix_classifier_0 (
        .clk          (clk),
        .reset        (reset),
        .retire_valid (retire_valid),
        .retire_instr (retire_instr),
        .port_mix     (port_mix),
        .port_valid_r (port_valid_r)
    );

    mix_counter_bank #(
        .RETIRE_PORTS (RETIRE_PORTS),
        .COUNTER_W    (COUNTER_W)
    ) mix_counter_bank_0 (
        .clk          (clk),
        .reset        (reset),
        .count_enable (count_enable),
        .count_clear  (count_clear),
        .port_mix     (port_mix),
        .port_valid_r (port_valid_r),
        .mix_count    (mix_count),
        .retire_total (retire_total)
    );

    //////////////////////////////////////////////////
    // Console capture
    uart_capture #(
        .UART_ADDR (UART_ADDR)
    ) uart_capture_0 (
        .clk         (clk),
        .reset       (reset),
        .write_valid (write_valid),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .write_uart  (write_uart),
        .uart_byte   (uart_byte)
    );

endmodule

//--- verification/retire_monitor_checker.sv
`timescale 1ns/1ps

module retire_monitor_checker #(
    parameter int          RETIRE_PORTS = 2,
    parameter int          COUNTER_W    = 32,
    parameter logic [31:0] UART_ADDR    = 32'h8800_1000
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       retire_valid [RETIRE_PORTS],
    input  retire_monitor_pkg::instr_t retire_instr [RETIRE_PORTS],
    input  logic                       write_valid,
    input  logic [31:0]                write_addr,
    input  logic [31:0]                write_data,
    input  logic                       collecting,
    input  logic                       window_done,
    input  logic [COUNTER_W-1:0]       mix_count [retire_monitor_pkg::NUM_MIX_CATEGORIES],
    input  logic [COUNTER_W-1:0]       retire_total,
    input  logic                       write_uart,
    input  logic [7:0]                 uart_byte,
    output logic                       check_failed
);

    import retire_monitor_pkg::*;

    logic                 m_collect;
    logic                 m_collect_d;
    logic                 m_done;
    logic                 m_uart;
    logic [7:0]           m_byte;
    logic                 pend_clear;
    logic [COUNTER_W-1:0] pend_incr [NUM_MIX_CATEGORIES];
    logic [COUNTER_W-1:0] pend_total;
    logic [COUNTER_W-1:0] m_count [NUM_MIX_CATEGORIES];
    logic [COUNTER_W-1:0] m_total;
    logic                 start_seen;
    logic                 end_seen;
    logic [COUNTER_W-1:0] cyc_incr [NUM_MIX_CATEGORIES];
    logic [COUNTER_W-1:0] cyc_total;

    initial check_failed = 1'b0;

    task automatic report_value(string name, logic [63:0] expected, logic [63:0] actual);
        $display("FAILED at %0t: %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
        check_failed = 1'b1;
    endtask

    // Category bits of one instruction
    function automatic mix_vector_t expected_mix(instr_t instr);
        mix_vector_t bits;
        logic [4:0]  op;
        bits = '0;
        op   = instr[6:2];
        if (op == ARITH && instr[25] && instr[14]) begin
            bits[MIX_DIV] = 1'b1;
        end else if (op == ARITH && instr[25]) begin
            bits[MIX_MUL] = 1'b1;
        end else if (op == ARITH || op == ARITH_IMM || op == AUIPC || op == LUI) begin
            bits[MIX_ALU] = 1'b1;
        end
        if (op == BRANCH || op == JAL || op == JALR) bits[MIX_BRANCH] = 1'b1;
        if (op == LOAD || op == AMO) bits[MIX_LOAD] = 1'b1;
        if (op == STORE || op == AMO) bits[MIX_STORE] = 1'b1;
        if (op == SYSTEM || op == FENCE) bits[MIX_MISC] = 1'b1;
        return bits;
    endfunction

    //////////////////////////////////////////////////
    // Reference model, one cycle of input per edge
    always_comb begin
        mix_vector_t bits;
        start_seen = 1'b0;
        end_seen   = 1'b0;
        cyc_total  = '0;
        for (int c = 0; c < NUM_MIX_CATEGORIES; c++) cyc_incr[c] = '0;
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            bits = expected_mix(retire_instr[p]);
            if (retire_valid[p]) begin
                start_seen |= (retire_instr[p] == START_MARKER_INSTR);
                end_seen   |= (retire_instr[p] == END_MARKER_INSTR);
                cyc_total  += COUNTER_W'(1);
                for (int c = 0; c < NUM_MIX_CATEGORIES; c++) begin
                    cyc_incr[c] += COUNTER_W'(bits[c]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            m_collect   <= 1'b0;
            m_collect_d <= 1'b0;
            m_done      <= 1'b0;
            m_uart      <= 1'b0;
            pend_clear  <= 1'b0;
            pend_total  <= '0;
            m_total     <= '0;
            for (int c = 0; c < NUM_MIX_CATEGORIES; c++) begin
                pend_incr[c] <= '0;
                m_count[c]   <= '0;
            end
        end else begin
            // End marker wins over start
            m_collect   <= end_seen ? 1'b0 : (start_seen | m_collect);
            m_collect_d <= m_collect;
            m_done      <= m_collect_d & ~m_collect;
            pend_clear  <= start_seen & ~end_seen;
            pend_total  <= m_collect ? cyc_total : '0;
            m_total     <= pend_clear ? '0 : m_total + pend_total;
            for (int c = 0; c < NUM_MIX_CATEGORIES; c++) begin
                pend_incr[c] <= m_collect ? cyc_incr[c] : '0;
                m_count[c]   <= pend_clear ? '0 : m_count[c] + pend_incr[c];
            end
            m_uart <= write_valid && (write_addr == UART_ADDR);
            if (write_valid && (write_addr == UART_ADDR)) m_byte <= write_data[7:0];
        end
    end

    //////////////////////////////////////////////////
    // Output checks against the model
    assert property (@(posedge clk) disable iff (reset) collecting == m_collect)
        else report_value("collecting", $sampled(m_collect), $sampled(collecting));
    assert property (@(posedge clk) disable iff (reset) window_done == m_done)
        else report_value("window_done", $sampled(m_done), $sampled(window_done));
    assert property (@(posedge clk) disable iff (reset) window_done |=> !window_done)
        else report_value("window_done width", 64'd0, 64'd1);
    assert property (@(posedge clk) disable iff (reset) retire_total == m_total)
        else report_value("retire_total", $sampled(m_total), $sampled(retire_total));
    assert property (@(posedge clk) disable iff (reset) write_uart == m_uart)
        else report_value("write_uart", $sampled(m_uart), $sampled(write_uart));
    assert property (@(posedge clk) disable iff (reset) m_uart |-> (uart_byte == m_byte))
        else report_value("uart_byte", $sampled(m_byte), $sampled(uart_byte));

    for (genvar g = 0; g < NUM_MIX_CATEGORIES; g++) begin : gen_count_check
        assert property (@(posedge clk) disable iff (reset) mix_count[g] == m_count[g])
            else report_value($sformatf("mix_count[%0d]", g), $sampled(m_count[g]),
                              $sampled(mix_count[g]));
    end

endmodule

//--- verification/tb_retire_monitor.sv
`timescale 1ns/1ps

module tb_retire_monitor;

    import retire_monitor_pkg::*;

    localparam int          RETIRE_PORTS = 2;
    localparam int          COUNTER_W    = 32;
    localparam logic [31:0] UART_ADDR    = 32'h8800_1000;
    localparam int          WAIT_LIMIT   = 20;

    // Directed encodings for classification corners
    localparam instr_t MUL_INSTR     = 32'h0220_80B3;
    localparam instr_t DIV_INSTR     = 32'h0220_C0B3;
    localparam instr_t AMO_INSTR     = 32'h0020_A0AF;
    localparam instr_t UNKNOWN_INSTR = 32'h0000_0053;

    logic                 clk;
    logic                 reset;
    logic                 retire_valid [RETIRE_PORTS];
    instr_t               retire_instr [RETIRE_PORTS];
    logic                 write_valid;
    logic [31:0]          write_addr;
    logic [31:0]          write_data;
    logic                 collecting;
    logic                 window_done;
    logic [COUNTER_W-1:0] mix_count [NUM_MIX_CATEGORIES];
    logic [COUNTER_W-1:0] retire_total;
    logic                 write_uart;
    logic [7:0]           uart_byte;
    logic                 check_failed;

    always #20 clk = ~clk;

    retire_monitor_top #(
        .RETIRE_PORTS (RETIRE_PORTS),
        .COUNTER_W    (COUNTER_W),
        .UART_ADDR    (UART_ADDR)
    ) dut0 (.*);

    retire_monitor_checker #(
        .RETIRE_PORTS (RETIRE_PORTS),
        .COUNTER_W    (COUNTER_W),
        .UART_ADDR    (UART_ADDR)
    ) checker0 (.*);

    task automatic abort_run(string reason);
        $display("** FAIL **");
        $fatal(1, "%s", reason);
    endtask

    always @(posedge check_failed) abort_run("Checker reported a mismatch");

    //////////////////////////////////////////////////
    // Random instruction from every opcode group
    function automatic instr_t random_instr();
        instr_t      instr;
        int unsigned kind;
        instr      = $urandom();
        kind       = $urandom_range(0, 13);
        instr[1:0] = 2'b11;
        case (kind)
            0, 1, 2: begin
                instr[6:2] = ARITH;
                instr[25]  = (kind != 0);
                if (kind != 0) instr[14] = (kind == 2);
            end
            3:  instr[6:2] = ARITH_IMM;
            4:  instr[6:2] = AUIPC;
            5:  instr[6:2] = LUI;
            6:  instr[6:2] = BRANCH;
            7:  instr[6:2] = JAL;
            8:  instr[6:2] = JALR;
            9:  instr[6:2] = LOAD;
            10: instr[6:2] = AMO;
            11: instr[6:2] = STORE;
            12: instr[6:2] = ($urandom_range(0, 1) != 0) ? SYSTEM : FENCE;
            default: instr[6:2] = 5'b10100;
        endcase
        // Keep markers out of random traffic
        if (instr == START_MARKER_INSTR || instr == END_MARKER_INSTR) instr[7] = 1'b1;
        return instr;
    endfunction

    task automatic drive_random_cycle();
        @(negedge clk);
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            retire_valid[p] = ($urandom_range(0, 3) != 0);
            retire_instr[p] = random_instr();
        end
        write_valid = ($urandom_range(0, 5) == 0);
        write_addr  = ($urandom_range(0, 1) != 0) ? UART_ADDR
                                                  : UART_ADDR ^ (32'h1 << $urandom_range(0, 31));
        write_data  = $urandom();
    endtask

    task automatic run_random(int cycles);
        repeat (cycles) drive_random_cycle();
    endtask

    task automatic drive_idle();
        @(negedge clk);
        for (int p = 0; p < RETIRE_PORTS; p++) retire_valid[p] = 1'b0;
        write_valid = 1'b0;
    endtask

    task automatic drive_directed(instr_t instr);
        drive_idle();
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            retire_valid[p] = 1'b1;
            retire_instr[p] = instr;
        end
    endtask

    // Marker on the first port, random traffic beside it
    task automatic drive_marker(instr_t marker);
        drive_random_cycle();
        retire_valid[0] = 1'b1;
        retire_instr[0] = marker;
    endtask

    task automatic drive_both_markers();
        drive_idle();
        retire_valid[0]                = 1'b1;
        retire_instr[0]                = START_MARKER_INSTR;
        retire_valid[RETIRE_PORTS-1]   = 1'b1;
        retire_instr[RETIRE_PORTS-1]   = END_MARKER_INSTR;
    endtask

    task automatic wait_collecting();
        int cycles;
        cycles = 0;
        while (collecting !== 1'b1) begin
            if (cycles == WAIT_LIMIT) abort_run("collecting did not rise after a start marker");
            drive_idle();
            cycles++;
        end
    endtask

    task automatic wait_window_done();
        int cycles;
        cycles = 0;
        while (window_done !== 1'b1) begin
            if (cycles == WAIT_LIMIT) abort_run("window_done did not pulse after an end marker");
            drive_idle();
            cycles++;
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        write_valid = 1'b0;
        write_addr  = '0;
        write_data  = '0;
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            retire_valid[p] = 1'b0;
            retire_instr[p] = '0;
        end
        void'($urandom(60684));
        repeat (8) @(negedge clk);
        reset = 1'b0;

        // Traffic before any window
        run_random(20);
        drive_marker(START_MARKER_INSTR);
        wait_collecting();
        run_random(60);
        drive_directed(MUL_INSTR);
        drive_directed(DIV_INSTR);
        drive_directed(AMO_INSTR);
        drive_directed(UNKNOWN_INSTR);
        run_random(10);
        drive_marker(END_MARKER_INSTR);
        wait_window_done();
        run_random(15);

        // Restart inside an open window
        drive_marker(START_MARKER_INSTR);
        wait_collecting();
        run_random(12);
        drive_marker(START_MARKER_INSTR);
        run_random(25);
        drive_both_markers();
        wait_window_done();
        run_random(10);
        drive_both_markers();
        run_random(10);
        repeat (4) drive_idle();

        if (check_failed) begin
            abort_run("Checker reported a mismatch");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- project.f
common/retire_monitor_pkg.sv
rtl/mix/mix_classifier.sv
rtl/mix/mix_counter_bank.sv
rtl/collection_control.sv
rtl/uart_capture.sv
rtl/retire_monitor_top.sv
verification/retire_monitor_checker.sv
verification/tb_retire_monitor.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log && \
verilator --binary --timing --assert -f project.f --top-module tb_retire_monitor \
    -o sim_tb && \
./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }
cat sim.log
grep -q '^\*\* PASS \*\*$' sim.log || { echo "Pass message not found"; exit 1; }
